// File: tb/cpuPatterns.txt
// M addr data = memory image word, S addr data = expected store in order (hex)
// H cycles = cycle in which halted first reads high, cycle 1 = first fetch (decimal)
M 0000 20B0  // lw  r1, 0x30(r0)
M 0001 2131  // lw  r2, 0x31(r0)
M 0002 0530  // add r3, r1, r2
M 0003 41B8  // sw  r3, 0x38(r0)
M 0004 0531  // sub r3, r1, r2
M 0005 41B9  // sw  r3, 0x39(r0)
M 0006 0532  // and r3, r1, r2
M 0007 41BA  // sw  r3, 0x3A(r0)
M 0008 0533  // or  r3, r1, r2
M 0009 41BB  // sw  r3, 0x3B(r0)
M 000A 08B4  // slt r3, r2, r1
M 000B 41BC  // sw  r3, 0x3C(r0)
M 000C 0480  // add r0, r1, r1, discarded
M 000D 403D  // sw  r0, 0x3D(r0)
M 000E 2232  // lw  r4, 0x32(r0)
M 000F 32FF  // lw  r5, -1(r4)
M 0010 528A  // sw  r5, 10(r4)
M 0011 3302  // lw  r6, 2(r4)
M 0012 537B  // sw  r6, -5(r4)
M 0013 6481  // beq r1, r1, +1 taken
M 0014 40A0  // sw  r1, 0x20(r0) skipped
M 0015 6501  // beq r1, r2, +1 not taken
M 0016 40B7  // sw  r1, 0x37(r0)
M 0017 8019  // jmp 0x19
M 0018 4121  // sw  r2, 0x21(r0) skipped
M 0019 413F  // sw  r2, 0x3F(r0)
M 001A E000  // end
M 0030 0007
M 0031 FFFD
M 0032 0034
M 0033 5A5A
M 0036 C3C3
S 0038 0004  // add
S 0039 000A  // sub
S 003A 0005  // and
S 003B FFFF  // or
S 003C 0001  // slt
S 003D 0000  // r0 still zero
S 003E 5A5A
S 002F C3C3
S 0037 0007  // after not-taken beq
S 003F FFFD  // jump target
H 101

// File: tb.f
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/arithmeticUnit.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/cpu.sv
tb/cpuTb.sv

// File: runSim.sh
#!/bin/sh
# Build the processor testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cpuTb -f tb.f -o cpuSim
./obj_dir/cpuSim > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

// File: tb/cpuTb.sv
/*
 * Testbench for the multi-cycle processor. Models the shared memory, loads
 * program, data and expected stores from the patterns file, then checks the
 * reset state, every store in order, the halt cycle and the quiet time after halt.
 */
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int clockPeriod     = 8;
    localparam int driveDelay      = 1;
    localparam int resetCycles     = 3;
    localparam int memAddrBits     = 8;
    localparam int memDepth        = 1 << memAddrBits;
    localparam int quietCycles     = 20;
    localparam int watchdogPerWord = 20;
    localparam int watchdogBase    = 200;

    logic                 clock;
    logic                 reset;
    logic [wordWidth-1:0] memReadData;
    memRequestT           memRequest;
    logic                 halted;

    // Loaded image and the live memory copied from it during reset
    logic [wordWidth-1:0] image [memDepth];
    logic [wordWidth-1:0] mem   [memDepth];

    logic [wordWidth-1:0] expAddress [$];
    logic [wordWidth-1:0] expData    [$];
    int                   expHaltCycle;
    int                   imageWords;
    bit                   imageLoaded;
    bit                   opened;
    int                   storeIndex;
    int                   errorCount;
    int                   checkCount;
    int                   cycle;

    cpu cpu_inst (
        .clock       (clock),
        .reset       (reset),
        .memReadData (memReadData),
        .memRequest  (memRequest),
        .halted      (halted)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // Same-cycle read that returns zero during reset
    assign memReadData = reset ? '0 : mem[memRequest.address[memAddrBits-1:0]];

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < memDepth; i++) begin
                mem[i] <= image[i];
            end
        end else if (memRequest.write) begin
            mem[memRequest.address[memAddrBits-1:0]] <= memRequest.writeData;
        end
    end

    task automatic reportMismatch(input string name, input logic [wordWidth-1:0] got,
                                  input logic [wordWidth-1:0] expected);
        errorCount++;
        $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected);
    endtask

    task automatic checkResetState(input memRequestT req, input logic haltedNow);
        checkCount++;
        if (req.read !== 1'b1)
            reportMismatch("memRequest.read", wordWidth'(req.read), wordWidth'(1));
        if (req.write !== 1'b0)
            reportMismatch("memRequest.write", wordWidth'(req.write), wordWidth'(0));
        if (req.address !== '0)
            reportMismatch("memRequest.address", req.address, '0);
        if (haltedNow !== 1'b0)
            reportMismatch("halted", wordWidth'(haltedNow), wordWidth'(0));
    endtask

    task automatic checkStore(input memRequestT req, input logic [wordWidth-1:0] address,
                              input logic [wordWidth-1:0] data);
        checkCount++;
        if (req.address !== address)
            reportMismatch("memRequest.address", req.address, address);
        if (req.writeData !== data)
            reportMismatch("memRequest.writeData", req.writeData, data);
    endtask

    task automatic checkHalt(input int cycles, input int expected, input logic haltedNow);
        checkCount++;
        if (cycles != expected) begin
            errorCount++;
            $display("[ERROR] %0t halted rise cycle: got %0d, expected %0d",
                     $time, cycles, expected);
        end
        if (haltedNow !== 1'b1)
            reportMismatch("halted", wordWidth'(haltedNow), wordWidth'(1));
    endtask

    // Address range and store order checks for one cycle
    task automatic watchBus();
        if ((memRequest.read || memRequest.write) &&
            memRequest.address >= wordWidth'(memDepth)) begin
            errorCount++;
            $display("Access outside the modelled memory at %0t, address %h",
                     $time, memRequest.address);
        end
        if (memRequest.write) begin
            if (storeIndex < expAddress.size()) begin
                checkStore(memRequest, expAddress[storeIndex], expData[storeIndex]);
                storeIndex++;
            end else begin
                errorCount++;
                $display("Unexpected store at %0t to address %h with data %h",
                         $time, memRequest.address, memRequest.writeData);
            end
        end
    endtask

    // Background pattern unique to each word
    task automatic fillImage();
        logic [memAddrBits-1:0] index;
        for (int i = 0; i < memDepth; i++) begin
            index    = memAddrBits'(i);
            image[i] = {index, ~index};
        end
    endtask

    task automatic loadPatterns(output bit ok);
        int                   fd;
        int                   code;
        string                line;
        string                tag;
        logic [wordWidth-1:0] fieldA;
        logic [wordWidth-1:0] fieldB;
        ok = 1'b0;
        fd = $fopen("tb/cpuPatterns.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Cannot open the patterns file tb/cpuPatterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip blank and comment lines
            if (code <= 0 || line.len() < 2 || line.substr(0, 1) == "//")
                continue;
            code = $sscanf(line, "%s", tag);
            if (tag == "M" || tag == "S") begin
                code = $sscanf(line, "%s %h %h", tag, fieldA, fieldB);
                if (code != 3) begin
                    errorCount++;
                    $display("Malformed line in the patterns file: %s", line);
                end else if (tag == "M") begin
                    image[fieldA[memAddrBits-1:0]] = fieldB;
                    imageWords++;
                end else begin
                    expAddress.push_back(fieldA);
                    expData.push_back(fieldB);
                end
            end else if (tag == "H") begin
                code = $sscanf(line, "%s %d", tag, expHaltCycle);
            end else begin
                errorCount++;
                $display("Unrecognised line in the patterns file: %s", line);
            end
        end
        $fclose(fd);
        if (imageWords == 0 || expHaltCycle == 0) begin
            errorCount++;
            $display("Patterns file holds no memory image or no halt cycle");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic runProgram();
        repeat (resetCycles) @(posedge clock);
        #driveDelay;
        reset = 1'b0;
        // Cycle 1 is the first fetch
        @(negedge clock);
        cycle = 1;
        checkResetState(memRequest, halted);
        // Early rise stops short of the expected cycle
        while (cycle < expHaltCycle && halted !== 1'b1) begin
            watchBus();
            @(negedge clock);
            cycle++;
        end
        checkHalt(cycle, expHaltCycle, halted);
        // Parked in halt with memory untouched
        for (int n = 0; n < quietCycles; n++) begin
            if (memRequest.write) begin
                errorCount++;
                $display("Memory write after halt at %0t, address %h",
                         $time, memRequest.address);
            end
            if (halted !== 1'b1)
                reportMismatch("halted", wordWidth'(halted), wordWidth'(1));
            @(negedge clock);
        end
        if (storeIndex != expAddress.size()) begin
            errorCount++;
            $display("Only %0d of %0d expected stores were seen",
                     storeIndex, expAddress.size());
        end
    endtask

    initial begin
        reset        = 1'b1;
        errorCount   = 0;
        checkCount   = 0;
        storeIndex   = 0;
        imageWords   = 0;
        expHaltCycle = 0;
        cycle        = 0;
        fillImage();
        loadPatterns(opened);
        imageLoaded = 1'b1;
        if (opened) begin
            runProgram();
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        int watchdogCycles;
        wait (imageLoaded);
        watchdogCycles = watchdogPerWord * imageWords + watchdogBase;
        #(watchdogCycles * clockPeriod);
        $display("Timeout, run did not finish within %0d cycles", watchdogCycles);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: rtl/cpu.sv
/*
 * Processor top level. Joins controller and datapath; memory lives
 * outside and answers memRequest combinationally on memReadData.
 */
`timescale 1ns/1ps

module cpu (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [cpuPkg::wordWidth-1:0]   memReadData,
    output cpuPkg::memRequestT             memRequest,
    output logic                           halted
);
    import cpuPkg::*;

    controlBundleT controls;
    opcodeT        opcode;

    // Sequencer
    controlUnit controlUnit_inst (
        .clock    (clock),
        .reset    (reset),
        .opcode   (opcode),
        .controls (controls),
        .halted   (halted)
    );

    // Registers, ALU and memory request
    dataPath dataPath_inst (
        .clock       (clock),
        .reset       (reset),
        .controls    (controls),
        .memReadData (memReadData),
        .memRequest  (memRequest),
        .opcode      (opcode)
    );

endmodule

// File: rtl/dataPath.sv
/*
 * Multi-cycle datapath steered by the controller's bundle.
 * Holds PC, IR, A, B, ALU-out and MDR around the register file and ALU,
 * and builds the memory request for fetch, load and store accesses.
 */
`timescale 1ns/1ps

module dataPath (
    input  logic                           clock,
    input  logic                           reset,
    input  cpuPkg::controlBundleT          controls,
    input  logic [cpuPkg::wordWidth-1:0]   memReadData,
    output cpuPkg::memRequestT             memRequest,
    output cpuPkg::opcodeT                 opcode
);
    import cpuPkg::*;

    logic [wordWidth-1:0]    pc;
    logic [wordWidth-1:0]    ir;
    logic [wordWidth-1:0]    regA;
    logic [wordWidth-1:0]    regB;
    logic [wordWidth-1:0]    aluOut;
    logic [wordWidth-1:0]    mdr;

    logic [wordWidth-1:0]    readDataA;
    logic [wordWidth-1:0]    readDataB;
    logic [wordWidth-1:0]    aluA;
    logic [wordWidth-1:0]    aluB;
    logic [wordWidth-1:0]    aluResult;
    logic                    aluZero;
    logic [wordWidth-1:0]    pcNext;
    logic                    pcLoad;
    logic [regAddrWidth-1:0] writeAddr;
    logic [wordWidth-1:0]    writeData;
    logic [wordWidth-1:0]    immExt;
    logic [wordWidth-1:0]    jumpTarget;

    // Instruction fields
    assign opcode     = opcodeT'(ir[opcodeLsb +: opcodeWidth]);
    assign immExt     = {{(wordWidth-immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};
    // Word-addressed jump, zero-extended
    assign jumpTarget = {{(wordWidth-jumpWidth){1'b0}}, ir[jumpWidth-1:0]};

    // PC and IR hold their value unless enabled
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (pcLoad) begin
                pc <= pcNext;
            end
            if (controls.irWrite) begin
                ir <= memReadData;
            end
        end
    end

    // Per-cycle staging registers
    always_ff @(posedge clock) begin
        regA   <= readDataA;
        regB   <= readDataB;
        aluOut <= aluResult;
        mdr    <= memReadData;
    end

    // Branch taken when A - B is zero
    assign pcLoad = controls.pcWrite | (controls.pcWriteCond & aluZero);

    always_comb begin
        case (controls.pcSource)
            pcFromAluOut: pcNext = aluOut;
            pcFromJump:   pcNext = jumpTarget;
            default:      pcNext = aluResult;
        endcase
    end

    // ALU operand select
    assign aluA = controls.aluSrcA ? regA : pc;

    always_comb begin
        case (controls.aluSrcB)
            srcBReg: aluB = regB;
            srcBOne: aluB = wordWidth'(1);
            default: aluB = immExt;
        endcase
    end

    // rt for loads, rd for R-type
    assign writeAddr = controls.regDst ? ir[rdLsb +: regAddrWidth]
                                       : ir[rtLsb +: regAddrWidth];
    assign writeData = controls.memToReg ? mdr : aluOut;

    registerFile registerFile_inst (
        .clock       (clock),
        .reset       (reset),
        .readAddrA   (ir[rsLsb +: regAddrWidth]),
        .readAddrB   (ir[rtLsb +: regAddrWidth]),
        .writeAddr   (writeAddr),
        .writeEnable (controls.regWrite),
        .writeData   (writeData),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

    arithmeticUnit arithmeticUnit_inst (
        .aluOp    (controls.aluOp),
        .funct    (ir[functWidth-1:0]),
        .operandA (aluA),
        .operandB (aluB),
        .result   (aluResult),
        .zero     (aluZero)
    );

    // Instruction fetch uses PC, data access uses ALU-out
    assign memRequest.address   = controls.iOrD ? aluOut : pc;
    assign memRequest.writeData = regB;
    assign memRequest.read      = controls.memRead;
    assign memRequest.write     = controls.memWrite;

endmodule

// File: rtl/controlUnit.sv
/*
 * Multi-cycle controller. One state per clock; decode and memAddress branch
 * on the opcode. Each state decodes into the datapath control bundle.
 * The end instruction parks the machine in halt and raises halted.
 */
`timescale 1ns/1ps

module controlUnit (
    input  logic                  clock,
    input  logic                  reset,
    input  cpuPkg::opcodeT        opcode,
    output cpuPkg::controlBundleT controls,
    output logic                  halted
);
    import cpuPkg::*;

    controlStateT state;
    controlStateT nextState;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetch;
        end else begin
            state <= nextState;
        end
    end

    // Next state
    always_comb begin
        nextState = fetch;
        case (state)
            fetch: nextState = decode;
            decode: begin
                case (opcode)
                    opLw, opSw: nextState = memAddress;
                    opBeq:      nextState = branch;
                    opJmp:      nextState = jump;
                    opEnd:      nextState = halt;
                    // R-type and spare codes 5, 6
                    default:    nextState = execute;
                endcase
            end
            memAddress:   nextState = (opcode == opLw) ? memReadState : memWriteState;
            memReadState: nextState = loadWriteback;
            execute:      nextState = rWriteback;
            // Stays put until reset
            halt:         nextState = halt;
            // Writeback, store, branch and jump all return to fetch
            default:      nextState = fetch;
        endcase
    end

    // State to control bundle
    always_comb begin
        controls = '0;
        controls.aluOp = addOp;
        case (state)
            fetch: begin
                // IR <= mem[PC], PC <= PC + 1
                controls.memRead  = 1'b1;
                controls.irWrite  = 1'b1;
                controls.aluSrcB  = srcBOne;
                controls.pcSource = pcFromAlu;
                controls.pcWrite  = 1'b1;
            end
            decode: begin
                // Branch target into ALU-out ahead of time
                controls.aluSrcB = srcBImm;
            end
            memAddress: begin
                controls.aluSrcA = 1'b1;
                controls.aluSrcB = srcBImm;
            end
            memReadState: begin
                controls.memRead = 1'b1;
                controls.iOrD    = 1'b1;
            end
            loadWriteback: begin
                controls.memToReg = 1'b1;
                controls.regWrite = 1'b1;
            end
            memWriteState: begin
                controls.memWrite = 1'b1;
                controls.iOrD     = 1'b1;
            end
            execute: begin
                controls.aluSrcA = 1'b1;
                controls.aluSrcB = srcBReg;
                controls.aluOp   = functOp;
            end
            rWriteback: begin
                controls.regDst   = 1'b1;
                controls.regWrite = 1'b1;
            end
            branch: begin
                // A - B, PC <= ALU-out when zero
                controls.aluSrcA     = 1'b1;
                controls.aluSrcB     = srcBReg;
                controls.aluOp       = subOp;
                controls.pcWriteCond = 1'b1;
                controls.pcSource    = pcFromAluOut;
            end
            jump: begin
                controls.pcWrite  = 1'b1;
                controls.pcSource = pcFromJump;
            end
            // halt keeps every strobe and enable low
            default: ;
        endcase
    end

    assign halted = (state == halt);

endmodule

// File: rtl/arithmeticUnit.sv
/*
 * Combinational ALU. The controller's operation code picks add or subtract
 * directly, or defers to the R-type function field. Zero flags a zero result.
 */
`timescale 1ns/1ps

module arithmeticUnit (
    input  cpuPkg::aluOpT                    aluOp,
    input  logic [cpuPkg::functWidth-1:0]    funct,
    input  logic [cpuPkg::wordWidth-1:0]     operandA,
    input  logic [cpuPkg::wordWidth-1:0]     operandB,
    output logic [cpuPkg::wordWidth-1:0]     result,
    output logic                             zero
);
    import cpuPkg::*;

    // Resolved operation, in function field encoding
    logic [functWidth-1:0] operation;

    always_comb begin
        case (aluOp)
            subOp:   operation = functSub;
            functOp: operation = funct;
            default: operation = functAdd;
        endcase
    end

    always_comb begin
        case (operation)
            functSub: result = operandA - operandB;
            functAnd: result = operandA & operandB;
            functOr:  result = operandA | operandB;
            // Signed compare
            functSlt: result = wordWidth'($signed(operandA) < $signed(operandB));
            default:  result = operandA + operandB;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: rtl/registerFile.sv
/*
 * Eight-entry register file, two combinational read ports and one
 * synchronous write port. Register 0 reads zero and ignores writes.
 */
`timescale 1ns/1ps

module registerFile (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [cpuPkg::regAddrWidth-1:0]   readAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0]   readAddrB,
    input  logic [cpuPkg::regAddrWidth-1:0]   writeAddr,
    input  logic                              writeEnable,
    input  logic [cpuPkg::wordWidth-1:0]      writeData,
    output logic [cpuPkg::wordWidth-1:0]      readDataA,
    output logic [cpuPkg::wordWidth-1:0]      readDataB
);
    import cpuPkg::*;

    logic [wordWidth-1:0] registers [registerCount];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < registerCount; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            // Entry 0 never written, so it stays at its reset zero
            registers[writeAddr] <= writeData;
        end
    end

    assign readDataA = registers[readAddrA];
    assign readDataB = registers[readAddrB];

endmodule

// File: rtl/cpuPkg.sv
/*
 * Shared definitions for the 16-bit multi-cycle processor.
 * Holds widths, instruction field positions, opcodes, ALU and mux codes,
 * the control bundle between controller and datapath, and the memory bus.
 */
package cpuPkg;

    // Word and field widths
    localparam int wordWidth     = 16;
    localparam int regAddrWidth  = 3;
    localparam int registerCount = 8;
    localparam int immWidth      = 7;
    localparam int jumpWidth     = 13;
    localparam int opcodeWidth   = 3;
    localparam int functWidth    = 4;

    // Field positions, opcode in the top bits
    localparam int opcodeLsb = 13;
    localparam int rsLsb     = 10;
    localparam int rtLsb     = 7;
    localparam int rdLsb     = 4;

    // Major opcodes; 5 and 6 fall back to R-type
    typedef enum logic [opcodeWidth-1:0] {
        opR   = 3'd0,
        opLw  = 3'd1,
        opSw  = 3'd2,
        opBeq = 3'd3,
        opJmp = 3'd4,
        opEnd = 3'd7
    } opcodeT;

    // R-type function field; unknown codes add
    localparam logic [functWidth-1:0] functAdd = 4'd0;
    localparam logic [functWidth-1:0] functSub = 4'd1;
    localparam logic [functWidth-1:0] functAnd = 4'd2;
    localparam logic [functWidth-1:0] functOr  = 4'd3;
    localparam logic [functWidth-1:0] functSlt = 4'd4;

    typedef enum logic [1:0] {
        addOp   = 2'd0,
        subOp   = 2'd1,
        functOp = 2'd2
    } aluOpT;

    // ALU operand B select
    localparam logic [1:0] srcBReg = 2'd0;
    localparam logic [1:0] srcBOne = 2'd1;
    localparam logic [1:0] srcBImm = 2'd2;

    // PC source select
    localparam logic [1:0] pcFromAlu    = 2'd0;
    localparam logic [1:0] pcFromAluOut = 2'd1;
    localparam logic [1:0] pcFromJump   = 2'd2;

    typedef enum logic [3:0] {
        fetch, decode, memAddress, memReadState, loadWriteback, memWriteState,
        execute, rWriteback, branch, jump, halt
    } controlStateT;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       iOrD;
        logic       memRead;
        logic       memWrite;
        logic       irWrite;
        logic       memToReg;
        logic       regWrite;
        logic       regDst;
        logic       aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] pcSource;
        aluOpT      aluOp;
    } controlBundleT;

    typedef struct packed {
        logic [wordWidth-1:0] address;
        logic [wordWidth-1:0] writeData;
        logic                 read;
        logic                 write;
    } memRequestT;

endpackage
